/* src/axi_mem_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// AXI memory subsystem types
// Bus widths plus the AXI channel and memory request/response structs
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package axi_mem_pkg;

    parameter int unsigned AXI_ADDR_W = 16;
    parameter int unsigned AXI_DATA_W = 32;
    parameter int unsigned AXI_ID_W   = 4;
    parameter int unsigned AXI_STRB_W = AXI_DATA_W / 8;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;   // beats minus one
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;        // same layout on both address channels

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic                  last;
    } axi_r_t;

    // manager to subordinate
    typedef struct packed {
        axi_aw_t aw;
        logic    aw_valid;
        axi_w_t  w;
        logic    w_valid;
        logic    b_ready;
        axi_ar_t ar;
        logic    ar_valid;
        logic    r_ready;
    } axi_req_t;

    // subordinate to manager
    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        axi_b_t  b;
        logic    b_valid;
        logic    ar_ready;
        axi_r_t  r;
        logic    r_valid;
    } axi_rsp_t;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  write;
    } mem_q_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_DATA_W-1:0] data;
    } mem_p_t;

    typedef struct packed {
        logic   q_valid;
        mem_q_t q;
    } mem_req_t;

    typedef struct packed {
        logic   q_ready;
        mem_p_t p;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* src/axi_write_path.sv */
////////////////////////////////////////////////////////////////////////////
// AXI write path
// Takes one INCR burst on AW/W, issues a memory write per beat and returns
// B once every beat has been acknowledged by the memory
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_write_path (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  axi_mem_pkg::axi_aw_t  aw_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  axi_mem_pkg::axi_w_t   w_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output axi_mem_pkg::axi_b_t   b_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i,
    output axi_mem_pkg::mem_req_t mem_req_o,
    input  axi_mem_pkg::mem_rsp_t mem_rsp_i
);
    import axi_mem_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_RESP} state_e;

    state_e                state_q;
    logic [AXI_ADDR_W-1:0] addr_q;
    logic [AXI_ID_W-1:0]   id_q;
    logic [8:0]            w_left_q;    // beats still to forward
    logic [8:0]            ack_left_q;  // acknowledges still due
    logic                  w_open;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;

    assign w_open     = (state_q == ST_DATA) && (w_left_q != '0);
    assign aw_ready_o = (state_q == ST_IDLE);
    assign aw_fire    = aw_valid_i && aw_ready_o;
    assign w_ready_o  = w_open && mem_rsp_i.q_ready;
    assign w_fire     = w_valid_i && w_ready_o;
    assign b_valid_o  = (state_q == ST_RESP);
    assign b_fire     = b_valid_o && b_ready_i;
    assign b_o.id     = id_q;

    // W beat goes straight out as the memory write
    assign mem_req_o.q_valid = w_open && w_valid_i;
    assign mem_req_o.q.addr  = addr_q;
    assign mem_req_o.q.data  = w_i.data;
    assign mem_req_o.q.strb  = w_i.strb;
    assign mem_req_o.q.write = 1'b1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            w_left_q   <= '0;
            ack_left_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (aw_fire) begin
                        state_q    <= ST_DATA;
                        w_left_q   <= {1'b0, aw_i.len} + 9'd1;
                        ack_left_q <= {1'b0, aw_i.len} + 9'd1;
                    end
                end
                ST_DATA: begin
                    if (w_fire) w_left_q <= w_left_q - 9'd1;
                    if (mem_rsp_i.p.valid) begin
                        ack_left_q <= ack_left_q - 9'd1;
                        if (ack_left_q == 9'd1) state_q <= ST_RESP;  // last beat in memory
                    end
                end
                ST_RESP: begin
                    if (b_fire) state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            addr_q <= aw_i.addr;
            id_q   <= aw_i.id;
        end else if (w_fire) begin
            addr_q <= addr_q + AXI_ADDR_W'(4);  // next word
        end
    end

endmodule

`default_nettype wire

/* src/axi_read_path.sv */
////////////////////////////////////////////////////////////////////////////
// AXI read path
// Unrolls one INCR read burst into memory reads and buffers the returned
// words so that R back-pressure never drops data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_read_path #(
    parameter int unsigned BufDepth = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  axi_mem_pkg::axi_ar_t  ar_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output axi_mem_pkg::axi_r_t   r_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    output axi_mem_pkg::mem_req_t mem_req_o,
    input  axi_mem_pkg::mem_rsp_t mem_rsp_i
);
    import axi_mem_pkg::*;

    localparam int unsigned PtrW = (BufDepth > 1) ? $clog2(BufDepth) : 1;
    localparam int unsigned CntW = $clog2(BufDepth + 1);

    logic                  busy_q;
    logic [AXI_ADDR_W-1:0] addr_q;
    logic [AXI_ID_W-1:0]   id_q;
    logic [7:0]            len_q;
    logic [8:0]            issue_left_q;  // reads not yet issued
    logic [7:0]            beat_q;        // R beats delivered so far
    logic [CntW-1:0]       fill_q;
    logic [CntW-1:0]       inflight_q;
    logic [CntW:0]         occupancy;
    logic [PtrW-1:0]       wr_ptr_q;
    logic [PtrW-1:0]       rd_ptr_q;
    logic [AXI_DATA_W-1:0] buf_q [BufDepth];
    logic                  req_valid;
    logic                  ar_fire;
    logic                  issue;
    logic                  rsp;
    logic                  r_fire;

    function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(BufDepth - 1)) ? '0 : ptr + PtrW'(1);
    endfunction

    // reserve a buffer slot for every read in flight
    assign occupancy = {1'b0, fill_q} + {1'b0, inflight_q};
    assign req_valid = busy_q && (issue_left_q != '0)
                       && (occupancy < (CntW + 1)'(BufDepth));

    assign ar_ready_o = !busy_q;
    assign ar_fire    = ar_valid_i && ar_ready_o;
    assign issue      = req_valid && mem_rsp_i.q_ready;
    assign rsp        = mem_rsp_i.p.valid;
    assign r_valid_o  = (fill_q != '0);
    assign r_fire     = r_valid_o && r_ready_i;

    assign r_o.id   = id_q;
    assign r_o.data = buf_q[rd_ptr_q];
    assign r_o.last = (beat_q == len_q);

    assign mem_req_o.q_valid = req_valid;
    assign mem_req_o.q.addr  = addr_q;
    assign mem_req_o.q.data  = '0;
    assign mem_req_o.q.strb  = '0;
    assign mem_req_o.q.write = 1'b0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            issue_left_q <= '0;
            beat_q       <= '0;
            fill_q       <= '0;
            inflight_q   <= '0;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
        end else begin
            if (ar_fire) begin
                busy_q       <= 1'b1;
                issue_left_q <= {1'b0, ar_i.len} + 9'd1;
                beat_q       <= '0;
            end else begin
                if (issue) issue_left_q <= issue_left_q - 9'd1;
                if (r_fire) begin
                    beat_q <= beat_q + 8'd1;
                    if (r_o.last) busy_q <= 1'b0;  // burst done
                end
            end
            if (rsp) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (r_fire) rd_ptr_q <= ptr_next(rd_ptr_q);
            fill_q     <= fill_q + CntW'(rsp) - CntW'(r_fire);
            inflight_q <= inflight_q + CntW'(issue) - CntW'(rsp);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            addr_q <= ar_i.addr;
            id_q   <= ar_i.id;
            len_q  <= ar_i.len;
        end else if (issue) begin
            addr_q <= addr_q + AXI_ADDR_W'(4);
        end
        if (rsp) buf_q[wr_ptr_q] <= mem_rsp_i.p.data;
    end

endmodule

`default_nettype wire

/* src/axi_to_mem_adapter.sv */
////////////////////////////////////////////////////////////////////////////
// AXI to memory adapter
// Splits the AXI port into a write and a read path, reads on memory
// port 0 and writes on memory port 1
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_to_mem_adapter #(
    parameter int unsigned BufDepth = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  axi_mem_pkg::axi_req_t       axi_req_i,
    output axi_mem_pkg::axi_rsp_t       axi_rsp_o,
    output axi_mem_pkg::mem_req_t [1:0] mem_req_o,
    input  axi_mem_pkg::mem_rsp_t [1:0] mem_rsp_i
);

    axi_write_path i_write_path (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .aw_i       (axi_req_i.aw),
        .aw_valid_i (axi_req_i.aw_valid),
        .aw_ready_o (axi_rsp_o.aw_ready),
        .w_i        (axi_req_i.w),
        .w_valid_i  (axi_req_i.w_valid),
        .w_ready_o  (axi_rsp_o.w_ready),
        .b_o        (axi_rsp_o.b),
        .b_valid_o  (axi_rsp_o.b_valid),
        .b_ready_i  (axi_req_i.b_ready),
        .mem_req_o  (mem_req_o[1]),  // write port
        .mem_rsp_i  (mem_rsp_i[1])
    );

    axi_read_path #(
        .BufDepth (BufDepth)
    ) i_read_path (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ar_i       (axi_req_i.ar),
        .ar_valid_i (axi_req_i.ar_valid),
        .ar_ready_o (axi_rsp_o.ar_ready),
        .r_o        (axi_rsp_o.r),
        .r_valid_o  (axi_rsp_o.r_valid),
        .r_ready_i  (axi_req_i.r_ready),
        .mem_req_o  (mem_req_o[0]),  // read port
        .mem_rsp_i  (mem_rsp_i[0])
    );

endmodule

`default_nettype wire

/* src/sram_dual_port.sv */
////////////////////////////////////////////////////////////////////////////
// Dual-port SRAM
// Registered read on port 0, byte-strobed write on port 1
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sram_dual_port #(
    parameter int unsigned MemWords = 256
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  axi_mem_pkg::mem_req_t [1:0] mem_req_i,
    output axi_mem_pkg::mem_rsp_t [1:0] mem_rsp_o
);
    import axi_mem_pkg::*;

    localparam int unsigned IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;

    logic [AXI_DATA_W-1:0] mem_q [MemWords];
    logic [AXI_ADDR_W-3:0] rd_word;
    logic [AXI_ADDR_W-3:0] wr_word;
    logic [IdxW-1:0]       rd_idx;
    logic [IdxW-1:0]       wr_idx;
    logic [AXI_DATA_W-1:0] rd_data_q;
    logic                  rd_valid_q;
    logic                  wr_valid_q;
    logic                  wr_en;

    // word index wraps at MemWords
    assign rd_word = mem_req_i[0].q.addr[AXI_ADDR_W-1:2];
    assign wr_word = mem_req_i[1].q.addr[AXI_ADDR_W-1:2];
    assign rd_idx  = IdxW'(rd_word % (AXI_ADDR_W - 2)'(MemWords));
    assign wr_idx  = IdxW'(wr_word % (AXI_ADDR_W - 2)'(MemWords));
    assign wr_en   = mem_req_i[1].q_valid && mem_req_i[1].q.write;

    assign mem_rsp_o[0].q_ready = 1'b1;
    assign mem_rsp_o[0].p.valid = rd_valid_q;
    assign mem_rsp_o[0].p.data  = rd_data_q;
    assign mem_rsp_o[1].q_ready = 1'b1;
    assign mem_rsp_o[1].p.valid = wr_valid_q;  // write acknowledge only
    assign mem_rsp_o[1].p.data  = '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= mem_req_i[0].q_valid;
            wr_valid_q <= mem_req_i[1].q_valid;
        end
    end

    // read sees the old word on a same-cycle collision
    always_ff @(posedge clk_i) begin
        if (mem_req_i[0].q_valid) rd_data_q <= mem_q[rd_idx];
        if (wr_en) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (mem_req_i[1].q.strb[b]) mem_q[wr_idx][b*8 +: 8] <= mem_req_i[1].q.data[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* src/axi_mem_top.sv */
////////////////////////////////////////////////////////////////////////////
// AXI memory top level
// AXI to memory adapter in front of a dual-port on-chip SRAM
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top #(
    parameter int unsigned BufDepth = 4,
    parameter int unsigned MemWords = 256
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  axi_mem_pkg::axi_req_t axi_req_i,
    output axi_mem_pkg::axi_rsp_t axi_rsp_o
);
    import axi_mem_pkg::*;

    mem_req_t [1:0] mem_req;  // 0 read, 1 write
    mem_rsp_t [1:0] mem_rsp;

    axi_to_mem_adapter #(
        .BufDepth (BufDepth)
    ) i_adapter (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .axi_req_i (axi_req_i),
        .axi_rsp_o (axi_rsp_o),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    sram_dual_port #(
        .MemWords (MemWords)
    ) i_sram (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

`default_nettype wire

/* verif/axi_mem_asserts.sv */
////////////////////////////////////////////////////////////////////////////
// AXI memory protocol assertions
// R and B hold under back-pressure, no memory request before AW or AR
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_mem_asserts (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  axi_mem_pkg::axi_req_t       axi_req_i,
    input  axi_mem_pkg::axi_rsp_t       axi_rsp_i,
    input  axi_mem_pkg::mem_req_t [1:0] mem_req_i
);

    logic addr_seen_q;  // an AW or AR has transferred since reset

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_seen_q <= 1'b0;
        end else if ((axi_req_i.aw_valid && axi_rsp_i.aw_ready)
                     || (axi_req_i.ar_valid && axi_rsp_i.ar_ready)) begin
            addr_seen_q <= 1'b1;
        end
    end

    r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        axi_rsp_i.r_valid && !axi_req_i.r_ready |=> axi_rsp_i.r_valid && $stable(axi_rsp_i.r))
        else $error("R beat changed or dropped before r_ready");

    b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        axi_rsp_i.b_valid && !axi_req_i.b_ready |=> axi_rsp_i.b_valid && $stable(axi_rsp_i.b))
        else $error("B response changed or dropped before b_ready");

    mem_after_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_i[0].q_valid || mem_req_i[1].q_valid) |-> addr_seen_q)
        else $error("memory request issued before any AW or AR transfer");

endmodule

bind axi_mem_top axi_mem_asserts i_asserts (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .axi_req_i (axi_req_i),
    .axi_rsp_i (axi_rsp_o),
    .mem_req_i (mem_req)
);

`default_nettype wire

/* verif/tb_axi_mem_top.sv */
////////////////////////////////////////////////////////////////////////////
// AXI memory testbench
// Directed bursts against a reference word model, with watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_top;
    import axi_mem_pkg::*;

    localparam int unsigned MEM_WORDS       = 256;
    localparam int unsigned TOTAL_BEATS     = 76;  // beats over all tests
    localparam int unsigned WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 1000;

    logic                  clk_i;
    logic                  rst_i;
    axi_req_t              req;
    axi_rsp_t              rsp;
    logic [AXI_DATA_W-1:0] model [MEM_WORDS];
    logic [AXI_DATA_W-1:0] wdata [16];
    logic [AXI_STRB_W-1:0] wstrb [16];
    int                    errors;
    int                    seed;

    axi_mem_top #(
        .BufDepth (4),
        .MemWords (MEM_WORDS)
    ) uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .axi_req_i (req),
        .axi_rsp_o (rsp)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    function automatic int word_idx(input logic [AXI_ADDR_W-1:0] addr);
        return int'(addr[AXI_ADDR_W-1:2]) % MEM_WORDS;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic fill_data(input int beats, input bit random_strb);
        for (int i = 0; i < beats; i++) begin
            wdata[i] = $random(seed);
            wstrb[i] = random_strb ? AXI_STRB_W'($random(seed)) : '1;
        end
    endtask

    task automatic model_write(input logic [AXI_ADDR_W-1:0] addr,
                               input logic [AXI_DATA_W-1:0] data,
                               input logic [AXI_STRB_W-1:0] strb);
        for (int b = 0; b < AXI_STRB_W; b++) begin
            if (strb[b]) model[word_idx(addr)][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    // called and left just after a falling edge
    task automatic axi_write_burst(input logic [3:0] id, input logic [AXI_ADDR_W-1:0] addr,
                                   input int beats, input int b_hold);
        req.aw.id    = id;
        req.aw.addr  = addr;
        req.aw.len   = 8'(beats - 1);
        req.aw_valid = 1'b1;
        while (!rsp.aw_ready) @(negedge clk_i);
        @(negedge clk_i);
        req.aw_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            req.w.data  = wdata[i];
            req.w.strb  = wstrb[i];
            req.w.last  = (i == beats - 1);
            req.w_valid = 1'b1;
            while (!rsp.w_ready) @(negedge clk_i);
            model_write(addr + AXI_ADDR_W'(4 * i), wdata[i], wstrb[i]);
            @(negedge clk_i);
        end
        req.w_valid = 1'b0;
        while (!rsp.b_valid) @(negedge clk_i);
        check_equal(rsp.b.id, id, "B id");
        repeat (b_hold) begin
            @(negedge clk_i);
            if (!rsp.b_valid) report_failure("b_valid dropped while b_ready was low");
            check_equal(rsp.b.id, id, "B id under back-pressure");
            if (rsp.aw_ready) report_failure("new AW could be accepted before B transferred");
        end
        req.b_ready = 1'b1;
        @(negedge clk_i);
        req.b_ready = 1'b0;
    endtask

    task automatic axi_read_burst(input logic [3:0] id, input logic [AXI_ADDR_W-1:0] addr,
                                  input int beats, input bit stall);
        int beat;
        req.ar.id    = id;
        req.ar.addr  = addr;
        req.ar.len   = 8'(beats - 1);
        req.ar_valid = 1'b1;
        while (!rsp.ar_ready) @(negedge clk_i);
        @(negedge clk_i);
        req.ar_valid = 1'b0;
        beat = 0;
        while (beat < beats) begin
            req.r_ready = stall ? 1'($random(seed)) : 1'b1;
            if (rsp.r_valid && req.r_ready) begin
                check_equal(rsp.r.data, model[word_idx(addr + AXI_ADDR_W'(4 * beat))],
                            $sformatf("R data beat %0d", beat));
                check_equal(rsp.r.id, id, "R id");
                if (rsp.r.last && beat != beats - 1)
                    report_failure($sformatf("r.last set early on beat %0d", beat));
                if (!rsp.r.last && beat == beats - 1)
                    report_failure("r.last missing on the final beat");
                beat++;
            end
            @(negedge clk_i);
        end
        req.r_ready = 1'b0;
    endtask

    task automatic reset_and_single_beat();
        check_equal(rsp.aw_ready, 1'b1, "aw_ready after reset");
        check_equal(rsp.ar_ready, 1'b1, "ar_ready after reset");
        check_equal(rsp.w_ready, 1'b0, "w_ready after reset");
        check_equal(rsp.b_valid, 1'b0, "b_valid after reset");
        check_equal(rsp.r_valid, 1'b0, "r_valid after reset");
        fill_data(1, 1'b0);
        axi_write_burst(4'h3, 16'h0010, 1, 0);
        axi_read_burst(4'h5, 16'h0010, 1, 1'b0);
    endtask

    task automatic strobed_burst_readback();
        fill_data(8, 1'b0);  // full words first so every byte is known
        axi_write_burst(4'h1, 16'h0040, 8, 0);
        fill_data(8, 1'b1);
        axi_write_burst(4'h2, 16'h0040, 8, 0);
        axi_read_burst(4'h6, 16'h0040, 8, 1'b0);
    endtask

    task automatic read_backpressure();
        fill_data(16, 1'b0);
        axi_write_burst(4'h7, 16'h0080, 16, 0);
        axi_read_burst(4'h9, 16'h0080, 16, 1'b1);
    endtask

    task automatic b_backpressure();
        fill_data(2, 1'b0);
        axi_write_burst(4'ha, 16'h0100, 2, 6);
        check_equal(rsp.aw_ready, 1'b1, "aw_ready after B transfer");
    endtask

    task automatic concurrent_read_write();
        fill_data(4, 1'b0);
        axi_write_burst(4'h1, 16'h0200, 4, 0);
        fill_data(4, 1'b0);
        fork
            axi_write_burst(4'hb, 16'h0300, 4, 0);
            axi_read_burst(4'hc, 16'h0200, 4, 1'b0);
        join
        axi_read_burst(4'hd, 16'h0300, 4, 1'b0);
    endtask

    initial begin
        seed   = 32'hc9eb289b;
        errors = 0;
        req    = '0;
        rst_i  = 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        reset_and_single_beat();
        strobed_burst_readback();
        read_backpressure();
        b_backpressure();
        concurrent_read_write();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("ERROR: watchdog expired after %0d cycles, a handshake never completed",
                 WATCHDOG_CYCLES);
        $display("errors: %0d", errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/axi_mem_pkg.sv
src/axi_write_path.sv
src/axi_read_path.sv
src/axi_to_mem_adapter.sv
src/sram_dual_port.sv
src/axi_mem_top.sv
verif/axi_mem_asserts.sv
verif/tb_axi_mem_top.sv

/* Bender.yml */
package:
  name: axi_mem

sources:
  - files:
      - src/axi_mem_pkg.sv
      - src/axi_write_path.sv
      - src/axi_read_path.sv
      - src/axi_to_mem_adapter.sv
      - src/sram_dual_port.sv
      - src/axi_mem_top.sv
  - target: test
    files:
      - verif/axi_mem_asserts.sv
      - verif/tb_axi_mem_top.sv
